// File: logic/dma_macros.svh
// Register map and sizes for a four-channel DMA whose counters are two bytes wide
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Sizes
`define DMA_CHANNELS 4
`define DMA_ADDR_WIDTH 16
`define DMA_COUNT_WIDTH 16
`define DMA_CREDIT_DEPTH 4

// Counter offsets, channel n sits at 2n and 2n+1
`define DMA_REG_ADDR_BASE 4'd0
`define DMA_REG_COUNT_BASE 4'd1

// Control and status offsets
`define DMA_REG_STATUS 4'd8
`define DMA_REG_REQUEST 4'd9
`define DMA_REG_SINGLE_MASK 4'd10
`define DMA_REG_MODE 4'd11
`define DMA_REG_CLEAR_FF 4'd12
`define DMA_REG_MASTER_CLEAR 4'd13
`define DMA_REG_CLEAR_MASK 4'd14
`define DMA_REG_ALL_MASK 4'd15

// Mode byte fields
`define DMA_MODE_AUTOINIT 4
`define DMA_MODE_DOWN 5

`endif

// File: logic/dmaPkg.sv
// Shared DMA types; their widths come from dma_macros.svh and the channel count must be a power of two
`include "dma_macros.svh"

package dmaPkg;

  // Channel selection
  typedef logic [$clog2(`DMA_CHANNELS)-1:0] channel_t;
  typedef logic [`DMA_CHANNELS-1:0] channelMask_t;

  // CPU side
  typedef logic [7:0] regByte_t;
  typedef logic [3:0] regAddr_t;

  // Counter words
  typedef logic [`DMA_ADDR_WIDTH-1:0] addrWord_t;
  typedef logic [`DMA_COUNT_WIDTH-1:0] countWord_t;

endpackage

// File: logic/dmaInterfaces.sv
// Internal DMA buses; they hold no clock and no logic, so every register sits in the attached modules

// CPU byte loads and master clear into one counter bank
interface counterLoadIf;
  import dmaPkg::*;

  logic load;
  logic clear;
  channel_t channel;
  logic highByte;
  regByte_t data;

  modport host (output load, clear, channel, highByte, data);
  modport bank (input load, clear, channel, highByte, data);
endinterface

// Transfer steps into one counter bank
interface counterStepIf #(
  parameter type counterWord_t = dmaPkg::addrWord_t
);
  import dmaPkg::*;

  logic step;
  channel_t channel;
  logic down;
  logic terminal;
  logic autoInit;
  // Current value of the named channel, combinational
  counterWord_t current;

  modport sequencer (output step, channel, down, terminal, autoInit, input current);
  modport bank (input step, channel, down, terminal, autoInit, output current);
endinterface

// Per-channel settings to the sequencer and TC events back to the host
interface channelControlIf;
  import dmaPkg::*;

  channelMask_t mask;
  channelMask_t softRequest;
  channelMask_t autoInit;
  channelMask_t down;
  logic tcEvent;
  channel_t tcChannel;

  modport host (
    output mask, softRequest, autoInit, down,
    input tcEvent, tcChannel
  );
  modport sequencer (
    input mask, softRequest, autoInit, down,
    output tcEvent, tcChannel
  );
endinterface

// File: logic/hostRegisterPort.sv
// CPU register port; mode bits 7:6 and 3:2 are ignored and reads of write-only offsets return zero
`include "dma_macros.svh"

module hostRegisterPort (
  input  logic dma_if,
  input  logic rst,
  input  logic cs,
  input  logic wr,
  input  logic rd,
  input  dmaPkg::regAddr_t regAddr,
  input  dmaPkg::regByte_t wrData,
  output dmaPkg::regByte_t rdData,
  input  dmaPkg::channelMask_t dreq,
  counterLoadIf.host addrLoad,
  counterLoadIf.host countLoad,
  input  dmaPkg::addrWord_t addrCurrents [`DMA_CHANNELS],
  input  dmaPkg::countWord_t countCurrents [`DMA_CHANNELS],
  channelControlIf.host ctrl
);
  import dmaPkg::*;

  logic writeEn;
  logic readEn;
  logic counterOffset;
  logic isCountReg;
  logic masterClear;
  logic bytePtr;
  channel_t regChannel;
  channel_t dataChannel;
  channelMask_t maskReg;
  channelMask_t softReqReg;
  channelMask_t autoInitReg;
  channelMask_t downReg;
  channelMask_t tcStatus;
  regByte_t statusByte;
  regByte_t counterByte;

  // Access decode
  assign writeEn = cs && wr;
  assign readEn = cs && rd;
  assign counterOffset = regAddr < `DMA_REG_STATUS;
  assign isCountReg = {3'b000, regAddr[0]} == `DMA_REG_COUNT_BASE;
  assign masterClear = writeEn && (regAddr == `DMA_REG_MASTER_CLEAR);
  assign regChannel = regAddr[2:1];
  assign dataChannel = wrData[1:0];

  // Byte loads into both banks
  assign addrLoad.load = writeEn && counterOffset && ({3'b000, regAddr[0]} == `DMA_REG_ADDR_BASE);
  assign addrLoad.clear = masterClear;
  assign addrLoad.channel = regChannel;
  assign addrLoad.highByte = bytePtr;
  assign addrLoad.data = wrData;

  assign countLoad.load = writeEn && counterOffset && isCountReg;
  assign countLoad.clear = masterClear;
  assign countLoad.channel = regChannel;
  assign countLoad.highByte = bytePtr;
  assign countLoad.data = wrData;

  // Low byte first, any counter access flips the pointer
  always_ff @(posedge dma_if)
  begin
    if (rst || masterClear || (writeEn && regAddr == `DMA_REG_CLEAR_FF))
      bytePtr <= 1'b0;
    else if (cs && (wr || rd) && counterOffset)
      bytePtr <= !bytePtr;
  end

  // Mode survives master clear
  always_ff @(posedge dma_if)
  begin
    if (rst)
    begin
      autoInitReg <= '0;
      downReg <= '0;
    end
    else if (writeEn && regAddr == `DMA_REG_MODE)
    begin
      autoInitReg[dataChannel] <= wrData[`DMA_MODE_AUTOINIT];
      downReg[dataChannel] <= wrData[`DMA_MODE_DOWN];
    end
  end

  always_ff @(posedge dma_if)
  begin
    if (rst || masterClear)
    begin
      maskReg <= '1;
      softReqReg <= '0;
      tcStatus <= '0;
    end
    else
    begin
      if (writeEn)
      begin
        case (regAddr)
          `DMA_REG_REQUEST: softReqReg[dataChannel] <= wrData[2];
          `DMA_REG_SINGLE_MASK: maskReg[dataChannel] <= wrData[2];
          `DMA_REG_ALL_MASK: maskReg <= wrData[3:0];
          `DMA_REG_CLEAR_MASK: maskReg <= '0;
          default: ;
        endcase
      end
      if (readEn && regAddr == `DMA_REG_STATUS)
        tcStatus <= '0;
      // TC comes last so a finished channel is never lost to a same-cycle access
      if (ctrl.tcEvent)
      begin
        tcStatus[ctrl.tcChannel] <= 1'b1;
        softReqReg[ctrl.tcChannel] <= 1'b0;
        if (!autoInitReg[ctrl.tcChannel])
          maskReg[ctrl.tcChannel] <= 1'b1;
      end
    end
  end

  // Read data
  assign statusByte = {dreq | softReqReg, tcStatus};

  always_comb
  begin
    if (isCountReg)
      counterByte = bytePtr ? countCurrents[regChannel][15:8] : countCurrents[regChannel][7:0];
    else
      counterByte = bytePtr ? addrCurrents[regChannel][15:8] : addrCurrents[regChannel][7:0];
  end

  always_ff @(posedge dma_if)
  begin
    if (rst || masterClear)
      rdData <= '0;
    else if (readEn)
    begin
      if (counterOffset)
        rdData <= counterByte;
      else if (regAddr == `DMA_REG_STATUS)
        rdData <= statusByte;
      else
        rdData <= '0;
    end
  end

  // Master clear blocks grants in its own cycle, so no step meets the clear
  assign ctrl.mask = maskReg | {`DMA_CHANNELS{masterClear}};
  assign ctrl.softRequest = softReqReg;
  assign ctrl.autoInit = autoInitReg;
  assign ctrl.down = downReg;

  loadExclusive: assert property (@(posedge dma_if) disable iff (rst)
    !(addrLoad.load && countLoad.load))
    else $error("address and count banks loaded in the same cycle");

endmodule

// File: logic/channelCounterBank.sv
// Base and current counters per channel; counter words must be exactly two bytes wide
`include "dma_macros.svh"

module channelCounterBank #(
  parameter type counterWord_t = dmaPkg::addrWord_t
) (
  input  logic dma_if,
  input  logic rst,
  counterLoadIf.bank load,
  counterStepIf.bank step,
  output counterWord_t currents [`DMA_CHANNELS]
);
  import dmaPkg::*;

  counterWord_t baseReg [`DMA_CHANNELS];
  counterWord_t currentReg [`DMA_CHANNELS];

  always_ff @(posedge dma_if)
  begin
    if (rst || load.clear)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        baseReg[i] <= '0;
        currentReg[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        // CPU byte writes go to base and current alike
        if (load.load && load.channel == channel_t'(i))
        begin
          if (load.highByte)
          begin
            baseReg[i][15:8] <= load.data;
            currentReg[i][15:8] <= load.data;
          end
          else
          begin
            baseReg[i][7:0] <= load.data;
            currentReg[i][7:0] <= load.data;
          end
        end
        else if (step.step && step.channel == channel_t'(i))
        begin
          if (step.terminal)
            currentReg[i] <= step.autoInit ? baseReg[i] : '0;
          else if (step.down)
            currentReg[i] <= currentReg[i] - 1'b1;
          else
            currentReg[i] <= currentReg[i] + 1'b1;
        end
      end
    end
  end

  assign step.current = currentReg[step.channel];
  assign currents = currentReg;

  // Host masks grants during a master clear
  stepNotInClear: assert property (@(posedge dma_if) disable iff (rst)
    !(step.step && load.clear))
    else $error("counter step during master clear");

endmodule

// File: logic/transferSequencer.sv
// Fixed-priority grant with credit flow control; the receiver must return at most DMA_CREDIT_DEPTH credits
`include "dma_macros.svh"

module transferSequencer (
  input  logic dma_if,
  input  logic rst,
  input  dmaPkg::channelMask_t dreq,
  channelControlIf.sequencer ctrl,
  counterStepIf.sequencer addrStep,
  counterStepIf.sequencer countStep,
  output logic memValid,
  output dmaPkg::addrWord_t memAddr,
  output dmaPkg::channel_t memChannel,
  output logic memTc,
  input  logic memCredit
);
  import dmaPkg::*;

  localparam int CreditWidth = $clog2(`DMA_CREDIT_DEPTH + 1);

  channelMask_t request;
  channel_t winner;
  logic anyRequest;
  logic grant;
  logic terminal;
  logic [CreditWidth-1:0] creditCount;

  assign request = (dreq | ctrl.softRequest) & ~ctrl.mask;

  // Lowest index wins
  always_comb
  begin
    winner = '0;
    anyRequest = 1'b0;
    for (int i = `DMA_CHANNELS - 1; i >= 0; i--)
    begin
      if (request[i])
      begin
        winner = channel_t'(i);
        anyRequest = 1'b1;
      end
    end
  end

  assign grant = anyRequest && (creditCount != '0);
  // Count of N gives N+1 transfers
  assign terminal = countStep.current == '0;

  assign addrStep.step = grant;
  assign addrStep.channel = winner;
  assign addrStep.down = ctrl.down[winner];
  assign addrStep.terminal = terminal;
  assign addrStep.autoInit = ctrl.autoInit[winner];

  assign countStep.step = grant;
  assign countStep.channel = winner;
  assign countStep.down = 1'b1;
  assign countStep.terminal = terminal;
  assign countStep.autoInit = ctrl.autoInit[winner];

  // Host masks the channel at the same edge, so no extra grant follows TC
  assign ctrl.tcEvent = grant && terminal;
  assign ctrl.tcChannel = winner;

  // Credit falls with each grant and is returned by the receiver
  always_ff @(posedge dma_if)
  begin
    if (rst)
      creditCount <= CreditWidth'(`DMA_CREDIT_DEPTH);
    else
      creditCount <= creditCount - CreditWidth'(grant) + CreditWidth'(memCredit);
  end

  always_ff @(posedge dma_if)
  begin
    if (rst)
      memValid <= 1'b0;
    else
      memValid <= grant;
  end

  // Pre-step address of the granted channel
  always_ff @(posedge dma_if)
  begin
    memAddr <= addrStep.current;
    memChannel <= winner;
    memTc <= terminal;
  end

  creditBound: assert property (@(posedge dma_if) disable iff (rst)
    creditCount <= CreditWidth'(`DMA_CREDIT_DEPTH))
    else $error("receiver returned more credits than were issued");

  validNeedsCredit: assert property (@(posedge dma_if) disable iff (rst)
    memValid |-> $past(creditCount) != '0)
    else $error("memValid issued with no credit");

endmodule

// File: logic/dmaController.sv
// Four-channel DMA top level with split CPU read and write data and a credit-based memory port
`include "dma_macros.svh"

module dmaController (
  input  logic dma_if,
  input  logic rst,
  input  logic cs,
  input  logic wr,
  input  logic rd,
  input  dmaPkg::regAddr_t regAddr,
  input  dmaPkg::regByte_t wrData,
  output dmaPkg::regByte_t rdData,
  input  dmaPkg::channelMask_t dreq,
  output logic memValid,
  output dmaPkg::addrWord_t memAddr,
  output dmaPkg::channel_t memChannel,
  output logic memTc,
  input  logic memCredit
);
  import dmaPkg::*;

  addrWord_t addrCurrents [`DMA_CHANNELS];
  countWord_t countCurrents [`DMA_CHANNELS];

  counterLoadIf addrLoadBus ();
  counterLoadIf countLoadBus ();
  counterStepIf #(.counterWord_t(addrWord_t)) addrStepBus ();
  counterStepIf #(.counterWord_t(countWord_t)) countStepBus ();
  channelControlIf ctrlBus ();

  hostRegisterPort hostPort (
    .dma_if(dma_if),
    .rst(rst),
    .cs(cs),
    .wr(wr),
    .rd(rd),
    .regAddr(regAddr),
    .wrData(wrData),
    .rdData(rdData),
    .dreq(dreq),
    .addrLoad(addrLoadBus.host),
    .countLoad(countLoadBus.host),
    .addrCurrents(addrCurrents),
    .countCurrents(countCurrents),
    .ctrl(ctrlBus.host)
  );

  // Address and count banks run side by side
  channelCounterBank #(.counterWord_t(addrWord_t)) addrBank (
    .dma_if(dma_if),
    .rst(rst),
    .load(addrLoadBus.bank),
    .step(addrStepBus.bank),
    .currents(addrCurrents)
  );

  channelCounterBank #(.counterWord_t(countWord_t)) countBank (
    .dma_if(dma_if),
    .rst(rst),
    .load(countLoadBus.bank),
    .step(countStepBus.bank),
    .currents(countCurrents)
  );

  transferSequencer sequencer (
    .dma_if(dma_if),
    .rst(rst),
    .dreq(dreq),
    .ctrl(ctrlBus.sequencer),
    .addrStep(addrStepBus.sequencer),
    .countStep(countStepBus.sequencer),
    .memValid(memValid),
    .memAddr(memAddr),
    .memChannel(memChannel),
    .memTc(memTc),
    .memCredit(memCredit)
  );

endmodule

// File: testbench/dmaModel.svh
// DMA reference model; transfers must be fed to it in the order the DUT issues them, and mode survives master clear
`ifndef DMA_MODEL_SVH
`define DMA_MODEL_SVH

localparam int XferBits = $bits(channel_t) + `DMA_ADDR_WIDTH + 1;

addrWord_t baseAddr [`DMA_CHANNELS];
addrWord_t curAddr [`DMA_CHANNELS];
countWord_t baseCount [`DMA_CHANNELS];
countWord_t curCount [`DMA_CHANNELS];
channelMask_t modelMask;
channelMask_t modelSoftReq;
channelMask_t modelAutoInit;
channelMask_t modelDown;
channelMask_t modelTcBits;
channelMask_t modelDreq;
logic modelPtr;

// Reset state, or master clear when keepMode is set
function automatic void resetModel(input logic keepMode);
  for (int i = 0; i < `DMA_CHANNELS; i++)
  begin
    baseAddr[i] = '0;
    curAddr[i] = '0;
    baseCount[i] = '0;
    curCount[i] = '0;
  end
  modelMask = '1;
  modelSoftReq = '0;
  modelTcBits = '0;
  modelPtr = 1'b0;
  if (!keepMode)
  begin
    modelAutoInit = '0;
    modelDown = '0;
  end
endfunction

function automatic void applyWrite(input regAddr_t addr, input regByte_t data);
  channel_t ch;
  channel_t target;
  ch = addr[2:1];
  target = data[1:0];
  if (addr < `DMA_REG_STATUS)
  begin
    // Byte goes to base and current alike
    if (addr[0] && modelPtr)
    begin
      baseCount[ch][15:8] = data;
      curCount[ch][15:8] = data;
    end
    else if (addr[0])
    begin
      baseCount[ch][7:0] = data;
      curCount[ch][7:0] = data;
    end
    else if (modelPtr)
    begin
      baseAddr[ch][15:8] = data;
      curAddr[ch][15:8] = data;
    end
    else
    begin
      baseAddr[ch][7:0] = data;
      curAddr[ch][7:0] = data;
    end
    modelPtr = !modelPtr;
  end
  else
  begin
    case (addr)
      `DMA_REG_REQUEST: modelSoftReq[target] = data[2];
      `DMA_REG_SINGLE_MASK: modelMask[target] = data[2];
      `DMA_REG_ALL_MASK: modelMask = data[3:0];
      `DMA_REG_CLEAR_MASK: modelMask = '0;
      `DMA_REG_CLEAR_FF: modelPtr = 1'b0;
      `DMA_REG_MASTER_CLEAR: resetModel(1'b1);
      `DMA_REG_MODE:
      begin
        modelAutoInit[target] = data[`DMA_MODE_AUTOINIT];
        modelDown[target] = data[`DMA_MODE_DOWN];
      end
      default: ;
    endcase
  end
endfunction

function automatic regByte_t expectRead(input regAddr_t addr);
  regByte_t value;
  logic [15:0] word;
  channel_t ch;
  ch = addr[2:1];
  value = '0;
  if (addr < `DMA_REG_STATUS)
  begin
    word = addr[0] ? curCount[ch] : curAddr[ch];
    value = modelPtr ? word[15:8] : word[7:0];
    modelPtr = !modelPtr;
  end
  else if (addr == `DMA_REG_STATUS)
  begin
    // TC bits clear on read
    value = {modelDreq | modelSoftReq, modelTcBits};
    modelTcBits = '0;
  end
  return value;
endfunction

// Lowest unmasked requesting channel, or -1 when none
function automatic int nextGrantChannel();
  channelMask_t pending;
  pending = (modelDreq | modelSoftReq) & ~modelMask;
  for (int i = 0; i < `DMA_CHANNELS; i++)
  begin
    if (pending[i])
      return i;
  end
  return -1;
endfunction

// Expected {channel, address, tc} of the next transfer on ch
function automatic logic [XferBits-1:0] predictTransfer(input channel_t ch);
  logic tc;
  addrWord_t addr;
  tc = curCount[ch] == '0;
  addr = curAddr[ch];
  if (tc)
  begin
    curAddr[ch] = modelAutoInit[ch] ? baseAddr[ch] : '0;
    curCount[ch] = modelAutoInit[ch] ? baseCount[ch] : '0;
    modelTcBits[ch] = 1'b1;
    modelSoftReq[ch] = 1'b0;
    if (!modelAutoInit[ch])
      modelMask[ch] = 1'b1;
  end
  else
  begin
    curCount[ch] = curCount[ch] - 1'b1;
    curAddr[ch] = modelDown[ch] ? curAddr[ch] - 1'b1 : curAddr[ch] + 1'b1;
  end
  return {ch, addr, tc};
endfunction

`endif

// File: testbench/dmaControllerTb.sv
// Fixed-seed DMA testbench; register writes must stay clear of active transfers
`include "dma_macros.svh"

module dmaControllerTb;
  import dmaPkg::*;

  logic dma_if = 1'b0;
  logic rst;
  logic cs;
  logic wr;
  logic rd;
  regAddr_t regAddr;
  regByte_t wrData;
  regByte_t rdData;
  channelMask_t dreq;
  logic memValid;
  addrWord_t memAddr;
  channel_t memChannel;
  logic memTc;
  logic memCredit = 1'b0;

  integer seed = 47637;
  integer creditSeed = 47637;
  int errorCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int observedCount = 0;
  int owed = 0;
  int creditWait = 0;
  logic creditPause = 1'b0;
  logic giveCredit;
  int cycleCount = 0;
  int timeoutLimit = 200;
  int nextCh;

  `include "dmaModel.svh"

  dmaController uut (
    .dma_if(dma_if),
    .rst(rst),
    .cs(cs),
    .wr(wr),
    .rd(rd),
    .regAddr(regAddr),
    .wrData(wrData),
    .rdData(rdData),
    .dreq(dreq),
    .memValid(memValid),
    .memAddr(memAddr),
    .memChannel(memChannel),
    .memTc(memTc),
    .memCredit(memCredit)
  );

  always #50 dma_if = !dma_if;

  always @(posedge dma_if)
  begin
    cycleCount++;
    if (cycleCount > timeoutLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  function automatic int randomInRange(input int lo, input int hi);
    int unsigned r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // Transfers are checked against the model as they come out
  always @(negedge dma_if)
  begin
    if (!rst && memValid)
    begin
      nextCh = nextGrantChannel();
      if (nextCh < 0)
      begin
        errorCount++;
        $display("Unexpected transfer on channel %0d at time %0t", memChannel, $time);
      end
      else
        checkValue(32'({memChannel, memAddr, memTc}),
                   32'(predictTransfer(channel_t'(nextCh))), "transfer channel, address, tc");
      observedCount++;
    end
  end

  // Credit receiver with a random 0 to 3 cycle gap
  always @(posedge dma_if)
  begin
    if (rst)
    begin
      owed <= 0;
      creditWait <= 0;
      memCredit <= 1'b0;
    end
    else
    begin
      giveCredit = !creditPause && owed > 0 && creditWait == 0;
      memCredit <= giveCredit;
      owed <= owed + int'(memValid) - int'(giveCredit);
      if (giveCredit)
        creditWait <= int'($random(creditSeed) & 3);
      else if (creditWait > 0)
        creditWait <= creditWait - 1;
      checkValue(32'(owed <= `DMA_CREDIT_DEPTH), 32'd1, "outstanding transfers within credits");
    end
  end

  task automatic writeReg(input regAddr_t addr, input regByte_t data);
    @(posedge dma_if);
    cs <= 1'b1;
    wr <= 1'b1;
    regAddr <= addr;
    wrData <= data;
    @(posedge dma_if);
    cs <= 1'b0;
    wr <= 1'b0;
    applyWrite(addr, data);
  endtask

  task automatic readCheck(input regAddr_t addr, input string what);
    regByte_t value;
    @(posedge dma_if);
    cs <= 1'b1;
    rd <= 1'b1;
    regAddr <= addr;
    @(posedge dma_if);
    cs <= 1'b0;
    rd <= 1'b0;
    @(negedge dma_if);
    value = rdData;
    checkValue(32'(value), 32'(expectRead(addr)), what);
  endtask

  task automatic programChannel(input channel_t ch, input addrWord_t addr,
                                input countWord_t count, input regByte_t mode);
    writeReg(`DMA_REG_CLEAR_FF, 8'h00);
    writeReg(`DMA_REG_MODE, {mode[7:2], ch});
    writeReg({1'b0, ch, 1'b0}, addr[7:0]);
    writeReg({1'b0, ch, 1'b0}, addr[15:8]);
    writeReg({1'b0, ch, 1'b1}, count[7:0]);
    writeReg({1'b0, ch, 1'b1}, count[15:8]);
  endtask

  task automatic readCounters(input channel_t ch);
    writeReg(`DMA_REG_CLEAR_FF, 8'h00);
    readCheck({1'b0, ch, 1'b0}, "address low byte");
    readCheck({1'b0, ch, 1'b0}, "address high byte");
    readCheck({1'b0, ch, 1'b1}, "count low byte");
    readCheck({1'b0, ch, 1'b1}, "count high byte");
  endtask

  task automatic waitTransfers(input int target);
    while (observedCount < target)
      @(posedge dma_if);
  endtask

  // No transfer in flight and every credit back at the DUT
  task automatic waitQuiet();
    while (owed != 0 || memValid)
      @(posedge dma_if);
    repeat (3) @(posedge dma_if);
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (errorCount == errorsBefore)
      $display("%s: pass", name);
    else
    begin
      testsFailed++;
      $display("%s: FAIL with %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  initial
  begin
    int errorsBefore;
    int startCount;
    int total;
    int n2;
    int n3;
    int n5;
    int n4 [`DMA_CHANNELS];
    channel_t ch;
    channel_t maskedCh;
    regByte_t mode;

    cs <= 1'b0;
    wr <= 1'b0;
    rd <= 1'b0;
    regAddr <= '0;
    wrData <= '0;
    dreq <= '0;
    rst <= 1'b1;
    resetModel(1'b0);
    modelDreq = '0;

    // Counts drawn up front so the timeout follows the test length
    n2 = randomInRange(3, 10);
    n3 = randomInRange(2, 6);
    n5 = randomInRange(5, 12);
    total = (n2 + 1) + 2 * (n3 + 1) + 4 + (n5 + 1) + 1;
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      n4[i] = randomInRange(1, 5);
      total += n4[i] + 1;
    end
    timeoutLimit = 40 * total + 200;

    repeat (5) @(posedge dma_if);
    rst <= 1'b0;

    // Test 1
    errorsBefore = errorCount;
    for (int i = 0; i < `DMA_CHANNELS; i++)
      programChannel(channel_t'(i), addrWord_t'($random(seed)), countWord_t'($random(seed)), 8'h00);
    for (int i = 0; i < `DMA_CHANNELS; i++)
      readCounters(channel_t'(i));
    // Odd access leaves the pointer on the high byte
    readCheck(`DMA_REG_ADDR_BASE, "address low byte before pointer clear");
    writeReg(`DMA_REG_CLEAR_FF, 8'h00);
    readCheck(`DMA_REG_ADDR_BASE, "address low byte after pointer clear");
    finishTest("Test 1 register readback", errorsBefore);

    // Test 2
    errorsBefore = errorCount;
    ch = channel_t'(randomInRange(0, 3));
    mode = regByte_t'(randomInRange(0, 1) << `DMA_MODE_DOWN);
    programChannel(ch, addrWord_t'($random(seed)), countWord_t'(n2), mode);
    startCount = observedCount;
    writeReg(`DMA_REG_SINGLE_MASK, {5'b00000, 1'b0, ch});
    writeReg(`DMA_REG_REQUEST, {5'b00000, 1'b1, ch});
    waitTransfers(startCount + n2 + 1);
    waitQuiet();
    checkValue(32'(observedCount - startCount), 32'(n2 + 1), "soft request transfer count");
    readCounters(ch);
    readCheck(`DMA_REG_STATUS, "status with TC bit");
    readCheck(`DMA_REG_STATUS, "status after clear on read");
    finishTest("Test 2 soft request", errorsBefore);

    // Test 3
    errorsBefore = errorCount;
    ch = channel_t'(randomInRange(0, 3));
    mode = regByte_t'((1 << `DMA_MODE_AUTOINIT) | (randomInRange(0, 1) << `DMA_MODE_DOWN));
    programChannel(ch, addrWord_t'($random(seed)), countWord_t'(n3), mode);
    startCount = observedCount;
    writeReg(`DMA_REG_SINGLE_MASK, {5'b00000, 1'b0, ch});
    writeReg(`DMA_REG_REQUEST, {5'b00000, 1'b1, ch});
    waitTransfers(startCount + n3 + 1);
    waitQuiet();
    readCounters(ch);
    readCheck(`DMA_REG_STATUS, "status after auto-init TC");
    @(posedge dma_if);
    startCount = observedCount;
    dreq <= channelMask_t'(1) << ch;
    modelDreq = channelMask_t'(1) << ch;
    waitTransfers(startCount + n3 + 3);
    dreq <= '0;
    waitQuiet();
    // Model drops dreq only once the last granted transfer is seen
    modelDreq = '0;
    writeReg(`DMA_REG_SINGLE_MASK, {5'b00000, 1'b1, ch});
    finishTest("Test 3 auto-initialize", errorsBefore);

    // Test 4
    errorsBefore = errorCount;
    maskedCh = channel_t'(randomInRange(0, 3));
    total = 0;
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      mode = regByte_t'(randomInRange(0, 1) << `DMA_MODE_DOWN);
      programChannel(channel_t'(i), addrWord_t'($random(seed)), countWord_t'(n4[i]), mode);
      if (channel_t'(i) != maskedCh)
        total += n4[i] + 1;
    end
    writeReg(`DMA_REG_ALL_MASK, {4'b0000, channelMask_t'(1) << maskedCh});
    @(posedge dma_if);
    startCount = observedCount;
    dreq <= '1;
    modelDreq = '1;
    waitTransfers(startCount + total);
    waitQuiet();
    checkValue(32'(observedCount - startCount), 32'(total), "priority transfer count");
    // Held dreq shows up as pending in the high nibble
    readCheck(`DMA_REG_STATUS, "status after priority run");
    @(posedge dma_if);
    dreq <= '0;
    modelDreq = '0;
    finishTest("Test 4 fixed priority", errorsBefore);

    // Test 5
    errorsBefore = errorCount;
    ch = channel_t'(randomInRange(0, 3));
    mode = regByte_t'(randomInRange(0, 1) << `DMA_MODE_DOWN);
    programChannel(ch, addrWord_t'($random(seed)), countWord_t'(n5), mode);
    @(posedge dma_if);
    creditPause <= 1'b1;
    startCount = observedCount;
    writeReg(`DMA_REG_SINGLE_MASK, {5'b00000, 1'b0, ch});
    writeReg(`DMA_REG_REQUEST, {5'b00000, 1'b1, ch});
    repeat (20) @(posedge dma_if);
    checkValue(32'(observedCount - startCount), 32'(`DMA_CREDIT_DEPTH),
               "transfers issued without returned credits");
    creditPause <= 1'b0;
    waitTransfers(startCount + n5 + 1);
    waitQuiet();
    checkValue(32'(observedCount - startCount), 32'(n5 + 1), "transfers after credits return");
    finishTest("Test 5 back-pressure", errorsBefore);

    // Test 6, the TC bit left by test 5 must be cleared by master clear
    errorsBefore = errorCount;
    ch = channel_t'(randomInRange(0, 3));
    programChannel(ch, addrWord_t'($random(seed)), countWord_t'(randomInRange(1, 5)), 8'h00);
    writeReg(`DMA_REG_CLEAR_MASK, 8'h00);
    writeReg(`DMA_REG_MASTER_CLEAR, 8'h00);
    readCheck(`DMA_REG_STATUS, "status after master clear");
    readCounters(ch);
    startCount = observedCount;
    writeReg(`DMA_REG_REQUEST, {5'b00000, 1'b1, ch});
    repeat (20) @(posedge dma_if);
    checkValue(32'(observedCount - startCount), 32'd0, "transfers while masked by master clear");
    writeReg(`DMA_REG_CLEAR_MASK, 8'h00);
    waitTransfers(startCount + 1);
    waitQuiet();
    checkValue(32'(observedCount - startCount), 32'd1, "transfers after clear mask");
    finishTest("Test 6 master clear", errorsBefore);

    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: dmaController.f
+incdir+logic
+incdir+testbench
logic/dmaPkg.sv
logic/dmaInterfaces.sv
logic/hostRegisterPort.sv
logic/channelCounterBank.sv
logic/transferSequencer.sv
logic/dmaController.sv
testbench/dmaControllerTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the DMA testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f dmaController.f --top-module dmaControllerTb -o simv

output=$(./obj_dir/simv)
echo "$output"

if grep -qx 'All tests passed!' <<< "$output"; then
  exit 0
fi
echo "Simulation did not report a pass" >&2
exit 1
